// ==== tests/programVectors.txt ====
# I <byte address> <instruction>, D <byte address> <data word>
# T <test name>, then E <store byte address> <store data> in program order
D 00000100 12345678
# ALU operations
I 00000000 12300093
I 00000004 FFB00113
I 00000008 20000513
I 0000000C 00400213
I 00000010 002081B3
I 00000014 00352023
I 00000018 402081B3
I 0000001C 00352223
I 00000020 001121B3
I 00000024 00352423
I 00000028 0020C1B3
I 0000002C 00352623
I 00000030 0020E1B3
I 00000034 00352823
I 00000038 0020F1B3
I 0000003C 00352A23
I 00000040 004091B3
I 00000044 00352C23
I 00000048 004151B3
I 0000004C 00352E23
I 00000050 404151B3
I 00000054 02352023
I 00000058 0F00C193
I 0000005C 02352223
I 00000060 7000E193
I 00000064 02352423
I 00000068 0F017193
I 0000006C 02352623
I 00000070 FFF12193
I 00000074 02352823
I 00000078 00809193
I 0000007C 02352A23
I 00000080 01C15193
I 00000084 02352C23
I 00000088 40115193
I 0000008C 02352E23
# dependent chain
I 00000090 00700293
I 00000094 00328293
I 00000098 00528333
I 0000009C 405303B3
I 000000A0 04752023
I 000000A4 04652223
# load then dependent add
I 000000A8 10000593
I 000000AC 0005A403
I 000000B0 001404B3
I 000000B4 04952423
I 000000B8 04852623
# branches and jal, then a jal to itself
I 000000BC 00100613
I 000000C0 00060463
I 000000C4 04C52823
I 000000C8 00061463
I 000000CC 04052A23
I 000000D0 00C60463
I 000000D4 04052A23
I 000000D8 04C52A23
I 000000DC 00C61463
I 000000E0 04152C23
I 000000E4 008006EF
I 000000E8 04052E23
I 000000EC 04D52E23
I 000000F0 0000006F
T aluOps
E 00000200 0000011E
E 00000204 00000128
E 00000208 00000001
E 0000020C FFFFFED8
E 00000210 FFFFFFFB
E 00000214 00000123
E 00000218 00001230
E 0000021C 0FFFFFFF
E 00000220 FFFFFFFF
E 00000224 000001D3
E 00000228 00000723
E 0000022C 000000F0
E 00000230 00000001
E 00000234 00012300
E 00000238 0000000F
E 0000023C FFFFFFFD
T forwarding
E 00000240 0000000A
E 00000244 00000014
T loadUse
E 00000248 1234579B
E 0000024C 12345678
T branchJal
E 00000250 00000001
E 00000254 00000001
E 00000258 00000123
E 0000025C 000000E8

// ==== sources.f ====
verilog/rvPkg.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/hazardUnit.sv
verilog/executeStage.sv
verilog/rvPipeline.sv
tests/tbClock.sv
tests/rvPipelineTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --top-module rvPipelineTb -f sources.f
output=$(./obj_dir/VrvPipelineTb)
echo "$output"
if echo "$output" | grep -qF '** PASS **'; then
    exit 0
fi
exit 1

// ==== tests/rvPipelineTb.sv ====
// RV32I pipeline testbench
`timescale 1ns/1ps

module rvPipelineTb;

    localparam int    resetCycles = 8;
    localparam string vectorFile  = "tests/programVectors.txt";

    logic        clk;
    logic        rst_n;
    logic        resetReq;
    logic        ICACHE_ren;
    logic [29:0] ICACHE_addr;
    logic        ICACHE_stall;
    logic [31:0] ICACHE_rdata;
    logic        DCACHE_ren;
    logic        DCACHE_wen;
    logic [29:0] DCACHE_addr;
    logic [31:0] DCACHE_wdata;
    logic        DCACHE_stall;
    logic [31:0] DCACHE_rdata;

    // memory models, big-endian byte order relative to the core
    logic [31:0] imem [256];
    logic [31:0] dmem [1024];

    // vectors as read from the file
    logic [31:0] instrAddr[$];
    logic [31:0] instrWord[$];
    logic [31:0] dataAddr[$];
    logic [31:0] dataWord[$];
    logic [31:0] expAddr[$];
    logic [31:0] expData[$];
    int          expTest[$];
    string       testNames[$];

    logic [31:0] lfsr;
    int          runIdx;
    int          storeIdx;
    int          errorCount;
    int          errAtTestStart;
    int          testsPassed;
    int          testsFailed;
    logic        hung;

    tbClock #(.periodNs(10), .resetCycles(resetCycles)) i_tbClock (
        .resetReq(resetReq), .clk(clk), .rst_n(rst_n)
    );

    rvPipeline #(.numRegs(32)) i_rvPipeline (
        .clk(clk), .rst_n(rst_n),
        .ICACHE_ren(ICACHE_ren), .ICACHE_addr(ICACHE_addr), .ICACHE_stall(ICACHE_stall),
        .ICACHE_rdata(ICACHE_rdata),
        .DCACHE_ren(DCACHE_ren), .DCACHE_wen(DCACHE_wen), .DCACHE_addr(DCACHE_addr),
        .DCACHE_wdata(DCACHE_wdata), .DCACHE_stall(DCACHE_stall), .DCACHE_rdata(DCACHE_rdata)
    );

    assign ICACHE_rdata = imem[ICACHE_addr[7:0]];
    // data port only answers a read that is enabled
    assign DCACHE_rdata = DCACHE_ren ? dmem[DCACHE_addr[9:0]] : '0;

    // ==================================================
    // helpers
    // ==================================================
    function automatic logic [31:0] swapBytes(input logic [31:0] v);
        return {v[7:0], v[15:8], v[23:16], v[31:24]};
    endfunction

    function automatic logic isPreloaded(input logic [31:0] addr);
        foreach (dataAddr[k]) begin
            if ({dataAddr[k][31:2], 2'b00} == addr) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Galois LFSR, one step per bit taken
    task automatic drawBit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic reportTest(input string name);
        if (errorCount == errAtTestStart) begin
            $display("run %0d test %s: ok", runIdx, name);
            testsPassed++;
        end else begin
            $display("run %0d test %s: failed", runIdx, name);
            testsFailed++;
        end
        errAtTestStart = errorCount;
    endtask

    task automatic loadVectors();
        int          fd;
        int          code;
        string       line;
        string       rest;
        byte         kind;
        logic [31:0] a;
        logic [31:0] v;
        fd = $fopen(vectorFile, "r");
        if (fd == 0) begin
            $display("cannot open the vector file %s", vectorFile);
            errorCount++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                while (line.len() > 0 && (line.getc(line.len() - 1) == 8'h0a ||
                       line.getc(line.len() - 1) == 8'h0d || line.getc(line.len() - 1) == " ")) begin
                    line = line.substr(0, line.len() - 2);
                end
                if (line.len() < 3 || line.getc(0) == "#") begin
                    continue;
                end
                kind = line.getc(0);
                rest = line.substr(2, line.len() - 1);
                if (kind == "T") begin
                    testNames.push_back(rest);
                    continue;
                end
                code = $sscanf(rest, "%h %h", a, v);
                if (code != 2 || (kind == "E" && testNames.size() == 0)) begin
                    $display("malformed vector line: %s", line);
                    errorCount++;
                end else if (kind == "I") begin
                    instrAddr.push_back(a);
                    instrWord.push_back(v);
                end else if (kind == "D") begin
                    dataAddr.push_back(a);
                    dataWord.push_back(v);
                end else if (kind == "E") begin
                    expAddr.push_back(a);
                    expData.push_back(v);
                    expTest.push_back(testNames.size() - 1);
                end else begin
                    $display("unknown vector line kind: %s", line);
                    errorCount++;
                end
            end
            $fclose(fd);
        end
        if (expAddr.size() == 0) begin
            $display("the vector file holds no expected stores");
            errorCount++;
        end
    endtask

    // address bits all enter the fill words, opcode 1111111 is a no-op
    task automatic fillMemories();
        for (int i = 0; i < 256; i++) begin
            imem[i] = swapBytes((32'(i) << 12) | 32'h0000_007f);
        end
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = 32'hDA7A_0000 ^ (32'(i) * 32'h0001_0003);
        end
        foreach (instrAddr[k]) begin
            imem[instrAddr[k][9:2]] = swapBytes(instrWord[k]);
        end
        foreach (dataAddr[k]) begin
            dmem[dataAddr[k][11:2]] = swapBytes(dataWord[k]);
        end
    endtask

    // ==================================================
    // one program run
    // ==================================================
    task automatic runProgram(input logic withStalls);
        int   cycles;
        int   limit;
        logic b0;
        logic b1;
        cycles = 0;
        limit  = 20 * instrAddr.size() + resetCycles;
        @(posedge clk);
        #1 resetReq = 1'b1;
        @(posedge clk);
        #1 resetReq = 1'b0;
        fillMemories();
        storeIdx       = 0;
        errAtTestStart = errorCount;
        while (!rst_n && cycles < 4 * resetCycles) begin
            @(posedge clk);
            cycles++;
        end
        cycles = 0;
        while (storeIdx < expAddr.size() && cycles < limit) begin
            @(posedge clk);
            #1;
            if (withStalls) begin
                drawBit(b0);
                drawBit(b1);
                ICACHE_stall = b0 & b1;
                drawBit(b0);
                drawBit(b1);
                DCACHE_stall = b0 & b1;
            end
            cycles++;
        end
        ICACHE_stall = 1'b0;
        DCACHE_stall = 1'b0;
        if (storeIdx < expAddr.size()) begin
            $display("run %0d hung: only %0d of %0d stores seen within %0d cycles",
                     runIdx, storeIdx, expAddr.size(), limit);
            errorCount++;
            hung = 1'b1;
        end
    endtask

    // cache strobes, the store model and completed stores in program order
    always @(posedge clk) begin
        string testName;
        checkValue($sformatf("run %0d icache read enable", runIdx), 32'(1), 32'(ICACHE_ren));
        if (!rst_n) begin
            if (DCACHE_ren === 1'b1 || DCACHE_wen === 1'b1) begin
                $display("run %0d: data cache strobe active during reset", runIdx);
                errorCount++;
            end
        end else begin
            if (DCACHE_ren && DCACHE_wen) begin
                $display("run %0d: data cache read and write enabled together", runIdx);
                errorCount++;
            end
            if (DCACHE_ren && !DCACHE_stall && !isPreloaded({DCACHE_addr, 2'b00})) begin
                $display("run %0d: load from %h, which holds no preloaded data",
                         runIdx, {DCACHE_addr, 2'b00});
                errorCount++;
            end
            if (DCACHE_wen && !DCACHE_stall) begin
                dmem[DCACHE_addr[9:0]] = DCACHE_wdata;
            end
            // a store stays in the memory stage until neither cache stalls
            if (DCACHE_wen && !DCACHE_stall && !ICACHE_stall) begin
                if (storeIdx >= expAddr.size()) begin
                    $display("run %0d: unexpected store to %h after the last expected one",
                             runIdx, {DCACHE_addr, 2'b00});
                    errorCount++;
                end else begin
                    testName = testNames[expTest[storeIdx]];
                    checkValue($sformatf("run %0d %s address", runIdx, testName),
                               expAddr[storeIdx], {DCACHE_addr, 2'b00});
                    checkValue($sformatf("run %0d %s data", runIdx, testName),
                               expData[storeIdx], swapBytes(DCACHE_wdata));
                    if (storeIdx + 1 == expAddr.size() ||
                        expTest[storeIdx + 1] != expTest[storeIdx]) begin
                        reportTest(testName);
                    end
                    storeIdx++;
                end
            end
        end
    end

    initial begin
        resetReq     = 1'b0;
        ICACHE_stall = 1'b0;
        DCACHE_stall = 1'b0;
        lfsr         = 32'h7608_ca00;
        errorCount   = 0;
        testsPassed  = 0;
        testsFailed  = 0;
        storeIdx     = 0;
        hung         = 1'b0;
        loadVectors();
        // second run repeats the program under random cache stalls
        for (runIdx = 0; runIdx < 2 && !hung; runIdx++) begin
            runProgram(runIdx == 1);
        end
        $display("%0d tests passed, %0d tests failed, %0d errors",
                 testsPassed, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== tests/tbClock.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module tbClock #(
    parameter int periodNs    = 10,
    parameter int resetCycles = 8
) (
    input  logic resetReq,
    output logic clk,
    output logic rst_n
);

    int count = 0;

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // reset restarts whenever the testbench asks for it
    always @(posedge clk) begin
        if (resetReq) begin
            count <= 0;
        end else if (count < resetCycles) begin
            count <= count + 1;
        end
    end

    assign rst_n = (count == resetCycles);

endmodule

// ==== verilog/rvPipeline.sv ====
// Five-stage RV32I pipeline
`timescale 1ns/1ps

module rvPipeline #(
    parameter int numRegs = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,
    // instruction cache
    output logic                    ICACHE_ren,
    output logic [rvPkg::addrW-1:0] ICACHE_addr,
    input  logic                    ICACHE_stall,
    input  logic [rvPkg::xlen-1:0]  ICACHE_rdata,
    // data cache
    output logic                    DCACHE_ren,
    output logic                    DCACHE_wen,
    output logic [rvPkg::addrW-1:0] DCACHE_addr,
    output logic [rvPkg::xlen-1:0]  DCACHE_wdata,
    input  logic                    DCACHE_stall,
    input  logic [rvPkg::xlen-1:0]  DCACHE_rdata
);

    localparam int xlen = rvPkg::xlen;
    localparam int rw   = rvPkg::regAddrW;

    // ==================================================
    // pipeline registers
    // ==================================================
    logic [xlen-1:0] pcReg;
    logic [xlen-1:0] ifIdPc;
    rvPkg::instrT    ifIdInstr;

    logic idExRegWrite, idExMemToReg, idExJal, idExBranch, idExMemRead, idExMemWrite;
    logic            idExAluSrc;
    rvPkg::aluOpT    idExAluOp;
    logic [xlen-1:0] idExPc, idExImm, idExOpA, idExOpB;
    logic [2:0]      idExFunct3;
    logic            idExFunct7b;
    logic [rw-1:0]   idExRd, idExRs1, idExRs2;

    logic exMemRegWrite, exMemMemToReg, exMemJal, exMemMemRead, exMemMemWrite;
    logic [xlen-1:0] exMemAlu, exMemStore, exMemTarget, exMemLink;
    logic [rw-1:0]   exMemRd;

    logic memWbRegWrite, memWbMemToReg, memWbJal;
    logic [xlen-1:0] memWbAlu, memWbLoad, memWbLink;
    logic [rw-1:0]   memWbRd;

    // stage outputs
    logic decJal, decBranch, decMemRead, decMemWrite, decMemToReg, decAluSrc, decRegWrite;
    rvPkg::aluOpT    decAluOp;
    logic [xlen-1:0] decImm, decOpA, decOpB, rfA, rfB;
    logic [2:0]      decFunct3;
    logic            decFunct7b;
    logic [rw-1:0]   decRd, decRs1, decRs2;
    rvPkg::fwdSelT   fwdDecA, fwdDecB, fwdExA, fwdExB;
    logic            loadUseStall, branchTaken;
    logic [xlen-1:0] aluResult, storeData, target, linkValue;

    // control
    logic            freeze, jalFlush, decStall, idFlush;
    logic [xlen-1:0] pcNext, fetchWord, loadWord, wbValue;

    assign freeze   = ICACHE_stall || DCACHE_stall;
    assign jalFlush = exMemJal;
    // a jal in memory redirects even if the flushed load would stall
    assign decStall = loadUseStall && !jalFlush;
    assign idFlush  = loadUseStall || branchTaken || jalFlush;

    assign pcNext = jalFlush    ? exMemTarget :
                    branchTaken ? target      :
                    decStall    ? pcReg       : pcReg + xlen'(4);

    // memory holds words in big-endian byte order
    assign fetchWord = {<<8{ICACHE_rdata}};
    assign loadWord  = {<<8{memWbLoad}};
    assign wbValue   = memWbJal ? memWbLink : (memWbMemToReg ? loadWord : memWbAlu);

    assign ICACHE_ren   = 1'b1;
    assign ICACHE_addr  = pcReg[xlen-1:2];
    assign DCACHE_ren   = exMemMemRead;
    assign DCACHE_wen   = exMemMemWrite;
    assign DCACHE_addr  = exMemAlu[xlen-1:2];
    assign DCACHE_wdata = {<<8{exMemStore}};

    // ==================================================
    // state update, frozen while either cache stalls
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pcReg         <= '0;
            ifIdInstr     <= rvPkg::nopInstr;
            idExRegWrite  <= 1'b0;
            idExMemToReg  <= 1'b0;
            idExJal       <= 1'b0;
            idExBranch    <= 1'b0;
            idExMemRead   <= 1'b0;
            idExMemWrite  <= 1'b0;
            exMemRegWrite <= 1'b0;
            exMemMemToReg <= 1'b0;
            exMemJal      <= 1'b0;
            exMemMemRead  <= 1'b0;
            exMemMemWrite <= 1'b0;
            memWbRegWrite <= 1'b0;
            memWbMemToReg <= 1'b0;
            memWbJal      <= 1'b0;
        end else if (!freeze) begin
            pcReg <= pcNext;
            if (!decStall) begin
                ifIdInstr <= (branchTaken || jalFlush) ? rvPkg::bubbleInstr : fetchWord;
            end
            // flush or load-use bubble into execute
            idExRegWrite  <= decRegWrite && !idFlush;
            idExMemToReg  <= decMemToReg && !idFlush;
            idExJal       <= decJal && !idFlush;
            idExBranch    <= decBranch && !idFlush;
            idExMemRead   <= decMemRead && !idFlush;
            idExMemWrite  <= decMemWrite && !idFlush;
            exMemRegWrite <= idExRegWrite && !jalFlush;
            exMemMemToReg <= idExMemToReg && !jalFlush;
            exMemJal      <= idExJal && !jalFlush;
            exMemMemRead  <= idExMemRead && !jalFlush;
            exMemMemWrite <= idExMemWrite && !jalFlush;
            memWbRegWrite <= exMemRegWrite;
            memWbMemToReg <= exMemMemToReg;
            memWbJal      <= exMemJal;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            if (!decStall) begin
                ifIdPc <= pcReg;
            end
            idExPc      <= ifIdPc;
            idExAluSrc  <= decAluSrc;
            idExAluOp   <= decAluOp;
            idExImm     <= decImm;
            idExOpA     <= decOpA;
            idExOpB     <= decOpB;
            idExFunct3  <= decFunct3;
            idExFunct7b <= decFunct7b;
            idExRd      <= decRd;
            idExRs1     <= decRs1;
            idExRs2     <= decRs2;
            exMemAlu    <= aluResult;
            exMemStore  <= storeData;
            exMemTarget <= target;
            exMemLink   <= linkValue;
            exMemRd     <= idExRd;
            memWbAlu    <= exMemAlu;
            memWbLoad   <= DCACHE_rdata;
            memWbLink   <= exMemLink;
            memWbRd     <= exMemRd;
        end
    end

    regFile #(.numRegs(numRegs)) i_regFile (
        .clk(clk), .rst_n(rst_n), .wen(memWbRegWrite), .wAddr(memWbRd), .wData(wbValue),
        .rAddrA(decRs1), .rAddrB(decRs2), .rDataA(rfA), .rDataB(rfB)
    );

    decodeStage i_decodeStage (
        .instr(ifIdInstr), .regA(rfA), .regB(rfB), .wbValue(wbValue), .memValue(exMemAlu),
        .fwdDecA(fwdDecA), .fwdDecB(fwdDecB), .jal(decJal), .branch(decBranch),
        .memRead(decMemRead), .memWrite(decMemWrite), .memToReg(decMemToReg),
        .aluSrc(decAluSrc), .regWrite(decRegWrite), .aluOp(decAluOp), .imm(decImm),
        .funct3(decFunct3), .funct7b(decFunct7b), .rd(decRd), .rs1(decRs1), .rs2(decRs2),
        .opA(decOpA), .opB(decOpB)
    );

    hazardUnit i_hazardUnit (
        .decRs1(decRs1), .decRs2(decRs2), .exRs1(idExRs1), .exRs2(idExRs2), .exRd(idExRd),
        .exMemRead(idExMemRead), .memRd(exMemRd), .memRegWrite(exMemRegWrite),
        .wbRd(memWbRd), .wbRegWrite(memWbRegWrite), .fwdDecA(fwdDecA), .fwdDecB(fwdDecB),
        .fwdExA(fwdExA), .fwdExB(fwdExB), .loadUseStall(loadUseStall)
    );

    executeStage i_executeStage (
        .aluOp(idExAluOp), .aluSrc(idExAluSrc), .branch(idExBranch), .funct3(idExFunct3),
        .funct7b(idExFunct7b), .imm(idExImm), .pc(idExPc), .regA(idExOpA), .regB(idExOpB),
        .wbValue(wbValue), .memValue(exMemAlu), .fwdExA(fwdExA), .fwdExB(fwdExB),
        .aluResult(aluResult), .storeData(storeData), .branchTaken(branchTaken),
        .target(target), .linkValue(linkValue)
    );

endmodule

// ==== verilog/executeStage.sv ====
// Execute stage ALU and branch resolution
`timescale 1ns/1ps

module executeStage (
    input  rvPkg::aluOpT           aluOp,
    input  logic                   aluSrc,
    input  logic                   branch,
    input  logic [2:0]             funct3,
    input  logic                   funct7b,
    input  logic [rvPkg::xlen-1:0] imm,
    input  logic [rvPkg::xlen-1:0] pc,
    input  logic [rvPkg::xlen-1:0] regA,
    input  logic [rvPkg::xlen-1:0] regB,
    input  logic [rvPkg::xlen-1:0] wbValue,
    input  logic [rvPkg::xlen-1:0] memValue,
    input  rvPkg::fwdSelT          fwdExA,
    input  rvPkg::fwdSelT          fwdExB,
    output logic [rvPkg::xlen-1:0] aluResult,
    output logic [rvPkg::xlen-1:0] storeData,
    output logic                   branchTaken,
    output logic [rvPkg::xlen-1:0] target,
    output logic [rvPkg::xlen-1:0] linkValue
);

    logic [rvPkg::xlen-1:0] opA;
    logic [rvPkg::xlen-1:0] opB;
    logic [rvPkg::xlen-1:0] aluB;
    logic [4:0]             shamt;
    rvPkg::aluCtrlT         aluCtrl;

    always_comb begin
        case (fwdExA)
            rvPkg::fwdWb:  opA = wbValue;
            rvPkg::fwdMem: opA = memValue;
            default:       opA = regA;
        endcase
        case (fwdExB)
            rvPkg::fwdWb:  opB = wbValue;
            rvPkg::fwdMem: opB = memValue;
            default:       opB = regB;
        endcase
    end

    assign aluB      = aluSrc ? imm : opB;
    assign shamt     = aluB[4:0];
    assign storeData = opB;

    // ==================================================
    // ALU control and ALU
    // ==================================================
    always_comb begin
        case (aluOp)
            rvPkg::aluReg: aluCtrl = rvPkg::aluCtrlT'({funct7b, funct3});
            rvPkg::aluImm: begin
                // bit 30 is part of the immediate except on srai
                if (funct3 == 3'b101 && funct7b) begin
                    aluCtrl = rvPkg::ctrlSra;
                end else begin
                    aluCtrl = rvPkg::aluCtrlT'({1'b0, funct3});
                end
            end
            // loads, stores, jal and branches
            default: aluCtrl = rvPkg::ctrlAdd;
        endcase
    end

    always_comb begin
        case (aluCtrl)
            rvPkg::ctrlAdd: aluResult = opA + aluB;
            rvPkg::ctrlSub: aluResult = opA - aluB;
            rvPkg::ctrlSlt: aluResult = ($signed(opA) < $signed(aluB)) ? rvPkg::xlen'(1) : '0;
            rvPkg::ctrlXor: aluResult = opA ^ aluB;
            rvPkg::ctrlOr:  aluResult = opA | aluB;
            rvPkg::ctrlAnd: aluResult = opA & aluB;
            rvPkg::ctrlSll: aluResult = opA << shamt;
            rvPkg::ctrlSrl: aluResult = opA >> shamt;
            rvPkg::ctrlSra: aluResult = $signed(opA) >>> shamt;
            default:        aluResult = '0;
        endcase
    end

    // beq with funct3 bit 0 clear, bne with it set
    assign branchTaken = branch && ((opA == opB) ^ funct3[0]);
    assign target      = pc + imm;
    assign linkValue   = pc + rvPkg::xlen'(4);

endmodule

// ==== verilog/hazardUnit.sv ====
// Forwarding selects and load-use detection
`timescale 1ns/1ps

module hazardUnit (
    input  logic [rvPkg::regAddrW-1:0] decRs1,
    input  logic [rvPkg::regAddrW-1:0] decRs2,
    input  logic [rvPkg::regAddrW-1:0] exRs1,
    input  logic [rvPkg::regAddrW-1:0] exRs2,
    input  logic [rvPkg::regAddrW-1:0] exRd,
    input  logic                       exMemRead,
    input  logic [rvPkg::regAddrW-1:0] memRd,
    input  logic                       memRegWrite,
    input  logic [rvPkg::regAddrW-1:0] wbRd,
    input  logic                       wbRegWrite,
    output rvPkg::fwdSelT              fwdDecA,
    output rvPkg::fwdSelT              fwdDecB,
    output rvPkg::fwdSelT              fwdExA,
    output rvPkg::fwdSelT              fwdExB,
    output logic                       loadUseStall
);

    logic memValid;
    logic wbValid;

    // x0 never forwards
    assign memValid = memRegWrite && memRd != '0;
    assign wbValid  = wbRegWrite && wbRd != '0;

    // decode side, writeback first
    assign fwdDecA = (wbValid && wbRd == decRs1)   ? rvPkg::fwdWb  :
                     (memValid && memRd == decRs1) ? rvPkg::fwdMem : rvPkg::fwdNone;
    assign fwdDecB = (wbValid && wbRd == decRs2)   ? rvPkg::fwdWb  :
                     (memValid && memRd == decRs2) ? rvPkg::fwdMem : rvPkg::fwdNone;

    // execute side, the younger memory-stage result wins
    assign fwdExA = (memValid && memRd == exRs1) ? rvPkg::fwdMem :
                    (wbValid && wbRd == exRs1)   ? rvPkg::fwdWb  : rvPkg::fwdNone;
    assign fwdExB = (memValid && memRd == exRs2) ? rvPkg::fwdMem :
                    (wbValid && wbRd == exRs2)   ? rvPkg::fwdWb  : rvPkg::fwdNone;

    // load data is only ready after the memory stage
    assign loadUseStall = exMemRead && exRd != '0 && (exRd == decRs1 || exRd == decRs2);

endmodule

// ==== verilog/decodeStage.sv ====
// Decode stage control and operands
`timescale 1ns/1ps

module decodeStage (
    input  rvPkg::instrT               instr,
    input  logic [rvPkg::xlen-1:0]     regA,
    input  logic [rvPkg::xlen-1:0]     regB,
    input  logic [rvPkg::xlen-1:0]     wbValue,
    input  logic [rvPkg::xlen-1:0]     memValue,
    input  rvPkg::fwdSelT              fwdDecA,
    input  rvPkg::fwdSelT              fwdDecB,
    output logic                       jal,
    output logic                       branch,
    output logic                       memRead,
    output logic                       memWrite,
    output logic                       memToReg,
    output logic                       aluSrc,
    output logic                       regWrite,
    output rvPkg::aluOpT               aluOp,
    output logic [rvPkg::xlen-1:0]     imm,
    output logic [2:0]                 funct3,
    output logic                       funct7b,
    output logic [rvPkg::regAddrW-1:0] rd,
    output logic [rvPkg::regAddrW-1:0] rs1,
    output logic [rvPkg::regAddrW-1:0] rs2,
    output logic [rvPkg::xlen-1:0]     opA,
    output logic [rvPkg::xlen-1:0]     opB
);

    rvPkg::rTypeT rView;
    rvPkg::iTypeT iView;
    logic [4:0]   opcode;

    assign rView   = instr.rType;
    assign iView   = instr.iType;
    assign opcode  = rView.opcode[6:2];
    assign rs1     = rView.rs1;
    assign rs2     = rView.rs2;
    assign rd      = rView.rd;
    assign funct3  = rView.funct3;
    assign funct7b = rView.funct7[5];

    // ==================================================
    // control flags
    // ==================================================
    always_comb begin
        jal      = 1'b0;
        branch   = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        aluSrc   = 1'b0;
        regWrite = 1'b0;
        aluOp    = rvPkg::aluAdd;
        case (opcode)
            rvPkg::opReg: begin
                regWrite = 1'b1;
                aluOp    = rvPkg::aluReg;
            end
            rvPkg::opImm: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = rvPkg::aluImm;
            end
            rvPkg::opLoad: begin
                memRead  = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            rvPkg::opStore: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            rvPkg::opBranch: begin
                branch = 1'b1;
                aluOp  = rvPkg::aluBranch;
            end
            rvPkg::opJal: begin
                jal      = 1'b1;
                regWrite = 1'b1;
            end
            // unknown opcodes stay a no-op
            default: aluOp = rvPkg::aluAdd;
        endcase
    end

    // immediate by format
    always_comb begin
        case (opcode)
            rvPkg::opStore: imm = {{20{rView.funct7[6]}}, rView.funct7, rView.rd};
            rvPkg::opBranch: imm = {{20{rView.funct7[6]}}, rView.rd[0], rView.funct7[5:0],
                                    rView.rd[4:1], 1'b0};
            rvPkg::opJal: imm = {{12{iView.imm12[11]}}, iView.rs1, iView.funct3,
                                 iView.imm12[0], iView.imm12[10:1], 1'b0};
            rvPkg::opLoad, rvPkg::opImm: imm = {{20{iView.imm12[11]}}, iView.imm12};
            default: imm = '0;
        endcase
    end

    // writeback forwarding covers a register write in this same cycle
    always_comb begin
        case (fwdDecA)
            rvPkg::fwdWb:  opA = wbValue;
            rvPkg::fwdMem: opA = memValue;
            default:       opA = regA;
        endcase
        case (fwdDecB)
            rvPkg::fwdWb:  opB = wbValue;
            rvPkg::fwdMem: opB = memValue;
            default:       opB = regB;
        endcase
    end

endmodule

// ==== verilog/regFile.sv ====
// Integer register file
`timescale 1ns/1ps

module regFile #(
    parameter int numRegs = 32
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wen,
    input  logic [rvPkg::regAddrW-1:0] wAddr,
    input  logic [rvPkg::xlen-1:0]     wData,
    input  logic [rvPkg::regAddrW-1:0] rAddrA,
    input  logic [rvPkg::regAddrW-1:0] rAddrB,
    output logic [rvPkg::xlen-1:0]     rDataA,
    output logic [rvPkg::xlen-1:0]     rDataB
);

    logic [rvPkg::xlen-1:0] regs [numRegs];

    // x0 is never written and keeps its reset value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wAddr != '0 && int'(wAddr) < numRegs) begin
            regs[wAddr] <= wData;
        end
    end

    // indices past numRegs read as zero
    assign rDataA = (int'(rAddrA) < numRegs) ? regs[rAddrA] : '0;
    assign rDataB = (int'(rAddrB) < numRegs) ? regs[rAddrB] : '0;

endmodule

// ==== verilog/rvPkg.sv ====
// RV32I pipeline shared definitions
package rvPkg;

    // ==================================================
    // widths and opcodes
    // ==================================================
    localparam int xlen     = 32;
    localparam int addrW    = 30;
    localparam int regAddrW = 5;

    // instruction bits 6 to 2
    localparam logic [4:0] opLoad   = 5'b00000;
    localparam logic [4:0] opStore  = 5'b01000;
    localparam logic [4:0] opBranch = 5'b11000;
    localparam logic [4:0] opJal    = 5'b11011;
    localparam logic [4:0] opImm    = 5'b00100;
    localparam logic [4:0] opReg    = 5'b01100;

    typedef enum logic [1:0] {
        aluAdd    = 2'b00,
        aluBranch = 2'b01,
        aluReg    = 2'b10,
        aluImm    = 2'b11
    } aluOpT;

    // encoded as {funct7 bit 5, funct3}
    typedef enum logic [3:0] {
        ctrlAdd = 4'b0000,
        ctrlSll = 4'b0001,
        ctrlSlt = 4'b0010,
        ctrlXor = 4'b0100,
        ctrlSrl = 4'b0101,
        ctrlOr  = 4'b0110,
        ctrlAnd = 4'b0111,
        ctrlSub = 4'b1000,
        ctrlSra = 4'b1101
    } aluCtrlT;

    typedef enum logic [1:0] {
        fwdNone = 2'b00,
        fwdWb   = 2'b01,
        fwdMem  = 2'b10
    } fwdSelT;

    // ==================================================
    // instruction word views
    // ==================================================
    typedef struct packed {
        logic [6:0]          funct7;
        logic [regAddrW-1:0] rs2;
        logic [regAddrW-1:0] rs1;
        logic [2:0]          funct3;
        logic [regAddrW-1:0] rd;
        logic [6:0]          opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0]         imm12;
        logic [regAddrW-1:0] rs1;
        logic [2:0]          funct3;
        logic [regAddrW-1:0] rd;
        logic [6:0]          opcode;
    } iTypeT;

    typedef union packed {
        rTypeT rType;
        iTypeT iType;
    } instrT;

    // addi x0, x0, 0
    localparam logic [xlen-1:0] nopInstr    = 32'h0000_0013;
    // opcode 11111 decodes to no control at all
    localparam logic [xlen-1:0] bubbleInstr = 32'h0000_007f;

endpackage
